// ==== rtl/pipe_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared definitions of the toy pipeline: widths, instruction field
// positions, opcodes and the payloads carried between stages.
// Modules pull these in with a wildcard import in their header.
////////////////////////////////////////////////////////////////////////////

package pipe_pkg;

    localparam int DATA_W  = 8;
    localparam int REG_N   = 4;
    localparam int REG_AW  = $clog2(REG_N);
    localparam int INSTR_W = 16;

    // Instruction layout, imm overlaps rs2
    localparam int OP_HI  = 15;
    localparam int OP_LO  = 12;
    localparam int RD_HI  = 11;
    localparam int RD_LO  = 10;
    localparam int RS1_HI = 9;
    localparam int RS1_LO = 8;
    localparam int RS2_HI = 7;
    localparam int RS2_LO = 6;
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Codes not listed here behave as NOP
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADDI  = 4'd1,
        ADD   = 4'd2,
        SUB   = 4'd3,
        SKIPZ = 4'd4
    } op_e;

    // Decode to execute
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        data_t     a;
        data_t     b;
        logic      we;
    } ex_payload_t;

    // Execute to write-back
    typedef struct packed {
        reg_addr_t rd;
        data_t     result;
        logic      we;
    } wb_payload_t;

    // A register write still in flight, seen by the hazard check
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
    } pend_t;

endpackage

// ==== rtl/stage_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Stage register bundle between two pipeline stages. The producing stage
// drives it through src, the next stage reads it through dst, and the
// tracer watches valid and seq through mon.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface stage_if #(
    parameter int  SEQ_W     = 8,
    parameter type payload_t = logic
);

    logic             valid;
    logic [SEQ_W-1:0] seq;
    logic [SEQ_W-1:0] stall_cycles;
    payload_t         payload;

    modport src (output valid, output seq, output stall_cycles, output payload);

    modport dst (input valid, input seq, input stall_cycles, input payload);

    modport mon (input valid, input seq);

endinterface

// ==== rtl/reg_file.sv ====
////////////////////////////////////////////////////////////////////////////
// Four entry register file with two combinational read ports and one
// write port that updates on the clock edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output data_t     rd_data_a,
    output data_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data
);

    data_t regs [REG_N];

    // No bypass, a write is visible from the next cycle on
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage. Accepts one instruction per strobe, reads its operands,
// stalls on pending writes and drops the instruction a taken skip kills.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage import pipe_pkg::*; #(
    parameter int SEQ_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    input  logic               flush,
    output logic               stall,
    output reg_addr_t          rd_addr_a,
    output reg_addr_t          rd_addr_b,
    input  data_t              rd_data_a,
    input  data_t              rd_data_b,
    input  pend_t              ex_pend,
    input  pend_t              wb_pend,
    stage_if.src               out
);

    logic               dec_valid;
    logic [INSTR_W-1:0] dec_instr;
    logic [SEQ_W-1:0]   dec_seq;
    logic [SEQ_W-1:0]   dec_stalls;
    logic [SEQ_W-1:0]   seq_cnt;
    logic               kill_pend;

    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      use_rs1;
    logic      use_rs2;
    logic      we;
    logic      hazard;
    logic      issue;
    logic      discard_new;

    assign rd  = dec_instr[RD_HI:RD_LO];
    assign rs1 = dec_instr[RS1_HI:RS1_LO];
    assign rs2 = dec_instr[RS2_HI:RS2_LO];
    assign imm = dec_instr[IMM_HI:IMM_LO];

    always_comb begin
        case (op_e'(dec_instr[OP_HI:OP_LO]))
            ADDI, ADD, SUB, SKIPZ: op = op_e'(dec_instr[OP_HI:OP_LO]);
            default:               op = NOP;
        endcase
    end

    assign use_rs1 = (op != NOP);
    assign use_rs2 = (op == ADD) || (op == SUB);
    assign we      = (op == ADDI) || (op == ADD) || (op == SUB);

    // Source registers still being written by execute or write-back
    assign hazard = (use_rs1 && ((ex_pend.we && ex_pend.rd == rs1) ||
                                 (wb_pend.we && wb_pend.rd == rs1))) ||
                    (use_rs2 && ((ex_pend.we && ex_pend.rd == rs2) ||
                                 (wb_pend.we && wb_pend.rd == rs2)));

    // A flush empties decode, so it also releases the stall
    assign stall = dec_valid && hazard && !flush;
    assign issue = instr_valid && !stall;

    // Skip taken with decode empty, the next accepted one dies instead
    assign discard_new = kill_pend || (flush && !dec_valid);

    assign rd_addr_a = rs1;
    assign rd_addr_b = rs2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_valid <= 1'b0;
            seq_cnt   <= '0;
            kill_pend <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            if (issue) begin
                seq_cnt   <= seq_cnt + 1'b1;
                kill_pend <= 1'b0;
                dec_valid <= !discard_new;
            end else begin
                if (flush && !dec_valid) begin
                    kill_pend <= 1'b1;
                end
                if (!stall) begin
                    dec_valid <= 1'b0;
                end
            end
            // Bubble downstream while stalled or flushed
            out.valid <= dec_valid && !stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dec_instr  <= instr;
            dec_seq    <= seq_cnt;
            dec_stalls <= '0;
        end else if (stall) begin
            dec_stalls <= dec_stalls + 1'b1;
        end
        out.seq          <= dec_seq;
        out.stall_cycles <= dec_stalls;
        out.payload      <= '{op: op, rd: rd, a: rd_data_a,
                              b: (op == ADDI) ? imm : rd_data_b, we: we};
    end

endmodule

// ==== rtl/execute_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute stage. Runs the ALU on the decoded operands, registers the
// result for write-back and raises flush on a taken skip.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module execute_stage import pipe_pkg::*; #(
    parameter int SEQ_W = 8
) (
    input  logic  clk,
    input  logic  rst,
    stage_if.dst  in,
    stage_if.src  out,
    output logic  flush,
    output pend_t ex_pend
);

    data_t result;

    always_comb begin
        case (in.payload.op)
            ADDI, ADD: result = in.payload.a + in.payload.b;
            SUB:       result = in.payload.a - in.payload.b;
            default:   result = in.payload.a;
        endcase
    end

    // Skip taken when its operand is zero
    assign flush = in.valid && (in.payload.op == SKIPZ) && (in.payload.a == '0);

    assign ex_pend = '{we: in.valid && in.payload.we, rd: in.payload.rd};

    always_ff @(posedge clk) begin
        if (!rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    // SKIPZ and NOP arrive with we low and keep it
    always_ff @(posedge clk) begin
        out.seq          <= in.seq[SEQ_W-1:0];
        out.stall_cycles <= in.stall_cycles[SEQ_W-1:0];
        out.payload      <= '{rd: in.payload.rd, result: result, we: in.payload.we};
    end

endmodule

// ==== rtl/writeback_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Write-back stage. Commits the result to the register file and pulses
// retire with the destination, write enable and value.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module writeback_stage import pipe_pkg::*; #(
    parameter int SEQ_W = 8
) (
    input  logic      clk,
    input  logic      rst,
    stage_if.dst      in,
    output pend_t     wb_pend,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output data_t     wr_data,
    output logic      retire,
    output reg_addr_t retire_rd,
    output logic      retire_we,
    output data_t     retire_value
);

    assign wr_en   = in.valid && in.payload.we;
    assign wr_addr = in.payload.rd;
    assign wr_data = in.payload.result;

    assign wb_pend = '{we: wr_en, rd: in.payload.rd};

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire <= 1'b0;
        end else begin
            retire <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd    <= in.payload.rd;
        retire_we    <= in.payload.we;
        retire_value <= in.payload.result;
    end

endmodule

// ==== rtl/pipe_tracer.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction tracer. Stamps each issued instruction with its issue cycle,
// counts its decode stalls, and reports the journey at retirement along
// with running stall and flush totals.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_tracer #(
    parameter int SEQ_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  logic             stall,
    input  logic             flush,
    input  logic             retire,
    stage_if.mon             wb_mon,
    output logic [SEQ_W-1:0] retire_seq,
    output logic [SEQ_W-1:0] retire_latency,
    output logic [SEQ_W-1:0] retire_stalls,
    output logic [SEQ_W-1:0] stall_count,
    output logic [SEQ_W-1:0] flush_count
);

    localparam int DEPTH = 2 ** SEQ_W;

    logic [SEQ_W-1:0] cycle;
    logic [SEQ_W-1:0] issue_seq;
    logic [SEQ_W-1:0] cur_seq;
    logic [SEQ_W-1:0] issue_tab [DEPTH];
    logic [SEQ_W-1:0] stall_tab [DEPTH];
    logic [SEQ_W-1:0] rec_issue;
    logic [SEQ_W-1:0] lat_live;
    logic [SEQ_W-1:0] lat_hold;

    ////////////////////////////////////////////////////////////////////////////
    // Free running cycle count and hazard totals

    always_ff @(posedge clk) begin
        if (!rst) begin
            cycle       <= '0;
            issue_seq   <= '0;
            stall_count <= '0;
            flush_count <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (issue) begin
                issue_seq <= issue_seq + 1'b1;
            end
            if (stall) begin
                stall_count <= stall_count + 1'b1;
            end
            if (flush) begin
                flush_count <= flush_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per instruction tables, indexed by sequence number

    // Stamp is the first cycle spent in decode
    always_ff @(posedge clk) begin
        if (issue) begin
            issue_tab[issue_seq] <= cycle + 1'b1;
            stall_tab[issue_seq] <= '0;
            cur_seq              <= issue_seq;
        end else if (stall) begin
            stall_tab[cur_seq] <= stall_tab[cur_seq] + 1'b1;
        end
    end

    // Look up the record while the instruction sits in write-back
    always_ff @(posedge clk) begin
        if (wb_mon.valid) begin
            retire_seq    <= wb_mon.seq;
            rec_issue     <= issue_tab[wb_mon.seq];
            retire_stalls <= stall_tab[wb_mon.seq];
        end
        if (retire) begin
            lat_hold <= lat_live;
        end
    end

    // Measured in the retire cycle, held until the next retirement
    assign lat_live       = cycle - rec_issue;
    assign retire_latency = retire ? lat_live : lat_hold;

endmodule

// ==== rtl/toy_pipe_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level of the toy pipeline. Joins decode, execute and write-back
// with the register file and the tracer behind plain ports.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module toy_pipe_top import pipe_pkg::*; #(
    parameter int SEQ_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    output logic               stall,
    output logic               retire_valid,
    output reg_addr_t          retire_rd,
    output logic               retire_we,
    output data_t              retire_value,
    output logic [SEQ_W-1:0]   retire_seq,
    output logic [SEQ_W-1:0]   retire_latency,
    output logic [SEQ_W-1:0]   retire_stalls,
    output logic [SEQ_W-1:0]   stall_count,
    output logic [SEQ_W-1:0]   flush_count
);

    logic      issue;
    logic      flush;
    pend_t     ex_pend;
    pend_t     wb_pend;
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    data_t     rd_data_a;
    data_t     rd_data_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    data_t     wr_data;

    assign issue = instr_valid && !stall;

    stage_if #(.SEQ_W(SEQ_W), .payload_t(ex_payload_t)) de_if ();
    stage_if #(.SEQ_W(SEQ_W), .payload_t(wb_payload_t)) ew_if ();

    reg_file i_reg_file (
        .clk(clk), .rst(rst),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    decode_stage #(.SEQ_W(SEQ_W)) i_decode (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr),
        .flush(flush), .stall(stall),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .ex_pend(ex_pend), .wb_pend(wb_pend),
        .out(de_if.src)
    );

    execute_stage #(.SEQ_W(SEQ_W)) i_execute (
        .clk(clk), .rst(rst),
        .in(de_if.dst), .out(ew_if.src),
        .flush(flush), .ex_pend(ex_pend)
    );

    writeback_stage #(.SEQ_W(SEQ_W)) i_writeback (
        .clk(clk), .rst(rst),
        .in(ew_if.dst), .wb_pend(wb_pend),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .retire(retire_valid), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value)
    );

    pipe_tracer #(.SEQ_W(SEQ_W)) i_tracer (
        .clk(clk), .rst(rst),
        .issue(issue), .stall(stall), .flush(flush), .retire(retire_valid),
        .wb_mon(ew_if.mon),
        .retire_seq(retire_seq), .retire_latency(retire_latency),
        .retire_stalls(retire_stalls),
        .stall_count(stall_count), .flush_count(flush_count)
    );

endmodule

// ==== testbench/tb_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the toy instruction set, included inside the testbench
// module. Keeps the architectural registers, the expected retirements in
// program order and the xorshift generator behind the random program.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [3:0]  OPC_NOP   = 4'd0;
localparam logic [3:0]  OPC_ADDI  = 4'd1;
localparam logic [3:0]  OPC_ADD   = 4'd2;
localparam logic [3:0]  OPC_SUB   = 4'd3;
localparam logic [3:0]  OPC_SKIPZ = 4'd4;
localparam logic [31:0] RNG_SEED  = 32'h7fe01d90;

// One instruction that is expected to reach write-back
typedef struct {
    int         seq;
    logic [1:0] rd;
    logic       we;
    logic [7:0] value;
    int         accept_cyc;
} retire_rec_t;

logic [7:0]  model_regs [4];
retire_rec_t exp_q [$];
logic        skip_next;
int          skips_taken;
logic [31:0] rng_state;

// Xorshift32, one step per call
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic model_reset();
    for (int i = 0; i < 4; i++) begin
        model_regs[i] = 8'd0;
    end
    exp_q.delete();
    skip_next   = 1'b0;
    skips_taken = 0;
    rng_state   = RNG_SEED;
endtask

// Runs one accepted instruction in program order
task automatic model_accept(input logic [15:0] ins, input int seq, input int acc_cyc);
    logic [3:0]  op;
    logic [1:0]  rs1;
    logic [1:0]  rs2;
    logic [7:0]  imm;
    retire_rec_t rec;
    op             = ins[15:12];
    rs1            = ins[9:8];
    rs2            = ins[7:6];
    imm            = ins[7:0];
    rec.seq        = seq;
    rec.rd         = ins[11:10];
    rec.we         = 1'b0;
    rec.value      = 8'd0;
    rec.accept_cyc = acc_cyc;
    if (skip_next) begin
        // Killed by the taken skip ahead of it
        skip_next = 1'b0;
    end else begin
        case (op)
            OPC_ADDI: begin
                rec.we    = 1'b1;
                rec.value = model_regs[rs1] + imm;
            end
            OPC_ADD: begin
                rec.we    = 1'b1;
                rec.value = model_regs[rs1] + model_regs[rs2];
            end
            OPC_SUB: begin
                rec.we    = 1'b1;
                rec.value = model_regs[rs1] - model_regs[rs2];
            end
            OPC_SKIPZ: begin
                if (model_regs[rs1] == 8'd0) begin
                    skip_next = 1'b1;
                    skips_taken++;
                end
            end
            default: begin
            end
        endcase
        if (rec.we) begin
            model_regs[rec.rd] = rec.value;
        end
        exp_q.push_back(rec);
    end
endtask

`endif

// ==== testbench/toy_pipe_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the toy pipeline. Feeds a random program through the
// input strobe, checks every retirement and the hazard counters against
// the reference model, and prints the result line at the end.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module toy_pipe_tb;

    localparam int SEQ_W           = 8;
    localparam int SEQ_MASK        = (1 << SEQ_W) - 1;
    localparam int N_INSTR         = 300;
    localparam int CLK_NS          = 100;
    localparam int WATCHDOG_CYCLES = N_INSTR * 8;

    logic             clk;
    logic             rst;
    logic             instr_valid;
    logic [15:0]      instr;
    logic             stall;
    logic             retire_valid;
    logic [1:0]       retire_rd;
    logic             retire_we;
    logic [7:0]       retire_value;
    logic [SEQ_W-1:0] retire_seq;
    logic [SEQ_W-1:0] retire_latency;
    logic [SEQ_W-1:0] retire_stalls;
    logic [SEQ_W-1:0] stall_count;
    logic [SEQ_W-1:0] flush_count;

    int         cyc;
    int         stall_seen;
    int         errors;
    int         checks;
    int         accepted;
    logic [1:0] last_rd;

    `include "tb_model.svh"

    toy_pipe_top #(.SEQ_W(SEQ_W)) i_dut (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr),
        .stall(stall), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_we(retire_we), .retire_value(retire_value),
        .retire_seq(retire_seq), .retire_latency(retire_latency),
        .retire_stalls(retire_stalls),
        .stall_count(stall_count), .flush_count(flush_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Check helpers and stimulus

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    // Sources lean on the last destination to make hazards common
    function automatic logic [15:0] random_instr();
        logic [31:0] r;
        logic [3:0]  op;
        logic [1:0]  rd;
        logic [1:0]  rs1;
        logic [7:0]  low;
        r = next_rand();
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: op = OPC_ADDI;
            4'd4, 4'd5, 4'd6:       op = OPC_ADD;
            4'd7, 4'd8, 4'd9:       op = OPC_SUB;
            4'd10, 4'd11, 4'd12:    op = OPC_SKIPZ;
            4'd13:                  op = OPC_NOP;
            default:                op = 4'd5 + (r[7:4] % 4'd11);
        endcase
        rd  = r[9:8];
        rs1 = r[21] ? last_rd : r[11:10];
        low = r[19:12];
        if (r[22]) begin
            low[7:6] = last_rd;
        end
        // Equal sources on SUB give zeros for SKIPZ to see
        if (op == OPC_SUB && r[20]) begin
            low[7:6] = rs1;
        end
        last_rd = rd;
        return {op, rd, rs1, low};
    endfunction

    // Retirement checks, sampled on the rising edge
    always @(posedge clk) begin
        retire_rec_t e;
        int          measured;
        cyc <= cyc + 1;
        if (rst === 1'b1) begin
            if (stall === 1'b1) begin
                stall_seen++;
            end
            if (retire_valid === 1'b1) begin
                check_true(exp_q.size() != 0, "retire_valid pulsed with nothing left to retire");
                if (exp_q.size() != 0) begin
                    e        = exp_q.pop_front();
                    measured = cyc - e.accept_cyc - 1;
                    check_equal($sformatf("seq %0d retire_seq", e.seq), e.seq & SEQ_MASK,
                                retire_seq);
                    check_equal($sformatf("seq %0d retire_rd", e.seq), e.rd, retire_rd);
                    check_equal($sformatf("seq %0d retire_we", e.seq), e.we, retire_we);
                    if (e.we) begin
                        check_equal($sformatf("seq %0d retire_value", e.seq), e.value,
                                    retire_value);
                    end
                    check_equal($sformatf("seq %0d retire_latency", e.seq),
                                measured & SEQ_MASK, retire_latency);
                    check_equal($sformatf("seq %0d retire_stalls", e.seq),
                                (measured - 3) & SEQ_MASK, retire_stalls);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = 16'h0000;
        cyc         = 0;
        stall_seen  = 0;
        errors      = 0;
        checks      = 0;
        accepted    = 0;
        last_rd     = 2'd0;
        model_reset();
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        check_equal("after reset stall", 0, stall);
        check_equal("after reset retire_valid", 0, retire_valid);
        check_equal("after reset stall_count", 0, stall_count);
        check_equal("after reset flush_count", 0, flush_count);
        instr       <= random_instr();
        instr_valid <= 1'b1;

        while (accepted < N_INSTR) begin
            @(posedge clk);
            if (instr_valid && !stall) begin
                model_accept(instr, accepted, cyc);
                accepted++;
                r = next_rand();
                // Occasional idle slot in the instruction stream
                if (accepted == N_INSTR || r[2:0] == 3'd0) begin
                    instr_valid <= 1'b0;
                end else begin
                    instr       <= random_instr();
                    instr_valid <= 1'b1;
                end
            end else if (!instr_valid) begin
                instr       <= random_instr();
                instr_valid <= 1'b1;
            end
        end

        // Drain, then watch a few more cycles for stray retirements
        for (int i = 0; i < 20 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        check_true(exp_q.size() == 0, "instructions still expected after the pipeline drained");
        check_equal("flush_count", skips_taken & SEQ_MASK, flush_count);
        check_equal("stall_count", stall_seen & SEQ_MASK, stall_count);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+testbench
rtl/pipe_pkg.sv
rtl/stage_if.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/pipe_tracer.sv
rtl/toy_pipe_top.sv
testbench/toy_pipe_tb.sv
